/* hw/iopmp_pkg.sv */
package iopmp_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int NUM_REGIONS = 8;
    localparam int NUM_CHAN    = 2;
    localparam int REG_ADDR_W  = 8;

    localparam int WORD_BYTES   = 4;
    localparam int DUMP_BYTES   = 8;  // Write address, then read address.
    localparam int REGION_BYTES = 8;  // Base, then mask.

    localparam logic [REG_ADDR_W-1:0] OFS_CTRL   = 8'h00;
    localparam logic [REG_ADDR_W-1:0] OFS_STAT   = 8'h08;
    localparam logic [REG_ADDR_W-1:0] OFS_DUMP   = 8'h10;
    localparam logic [REG_ADDR_W-1:0] OFS_REGION = 8'h20;  // Channel 1 follows at 0x60.

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [1:0] {
        HRESP_OKAY  = 2'b00,
        HRESP_ERROR = 2'b01
    } hresp_e;

    typedef struct packed {
        logic [ADDR_W-1:0] haddr;
        logic [3:0]        hprot;
        logic [2:0]        hsize;
        htrans_e           htrans;
        logic [2:0]        hburst;
        logic              hwrite;
        logic [DATA_W-1:0] hwdata;  // Data phase.
    } ahb_req_t;

    typedef struct packed {
        hresp_e            hresp;
        logic              hready;
        logic [DATA_W-1:0] hrdata;
    } ahb_rsp_t;

    typedef struct packed {
        logic [NUM_REGIONS-1:0]            en_w;
        logic [NUM_REGIONS-1:0]            en_r;
        logic [DATA_W-2*NUM_REGIONS-2:0]   rsvd;
        logic                              rst;  // Clears status and dump.
    } pmp_ctrl_t;

    typedef struct packed {
        logic [NUM_REGIONS-1:0]            hit_w;
        logic [NUM_REGIONS-1:0]            hit_r;
        logic [DATA_W-2*NUM_REGIONS-3:0]   rsvd;
        logic                              err_w;
        logic                              err_r;
    } pmp_stat_t;

    typedef struct packed {
        logic [ADDR_W-1:0] mask;
        logic [ADDR_W-1:0] base;
    } pmp_region_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr_w;
        logic [ADDR_W-1:0] addr_r;
    } pmp_dump_t;

endpackage

/* hw/iopmp_cfg_regs.sv */
module iopmp_cfg_regs (
    input  logic                   hclk_i,
    input  logic                   hresetn_i,

    input  logic                   hsel_i,
    input  iopmp_pkg::ahb_req_t    req_i,
    output iopmp_pkg::ahb_rsp_t    rsp_o,

    input  iopmp_pkg::pmp_stat_t   stat_i   [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::pmp_dump_t   dump_i   [iopmp_pkg::NUM_CHAN],

    output iopmp_pkg::pmp_ctrl_t   ctrl_o   [iopmp_pkg::NUM_CHAN],
    output iopmp_pkg::pmp_region_t region_o [iopmp_pkg::NUM_CHAN][iopmp_pkg::NUM_REGIONS]
);

    logic                             active;
    logic [iopmp_pkg::REG_ADDR_W-1:0] ap_ofs;
    logic                             wr_en_q;
    logic [iopmp_pkg::REG_ADDR_W-1:0] wr_ofs_q;
    iopmp_pkg::pmp_ctrl_t             wr_ctrl;
    logic [iopmp_pkg::DATA_W-1:0]     rd_data;
    logic [iopmp_pkg::DATA_W-1:0]     hrdata_q;

    // Byte offset of the base word of region r in channel c.
    function automatic int region_ofs(input int c, input int r);
        return iopmp_pkg::OFS_REGION + iopmp_pkg::REGION_BYTES * (c * iopmp_pkg::NUM_REGIONS + r);
    endfunction

    assign active = (req_i.htrans == iopmp_pkg::HTRANS_NONSEQ) ||
                    (req_i.htrans == iopmp_pkg::HTRANS_SEQ);
    assign ap_ofs = req_i.haddr[iopmp_pkg::REG_ADDR_W-1:0];

    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= hsel_i && active && req_i.hwrite;  // Never stalls.
        end
    end

    always_ff @(posedge hclk_i) begin
        wr_ofs_q <= ap_ofs;
    end

    always_comb begin
        wr_ctrl      = iopmp_pkg::pmp_ctrl_t'(req_i.hwdata);
        wr_ctrl.rsvd = '0;
    end

    // Data phase of a write.
    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            for (int c = 0; c < iopmp_pkg::NUM_CHAN; c++) begin
                ctrl_o[c] <= '0;
                for (int r = 0; r < iopmp_pkg::NUM_REGIONS; r++) begin
                    region_o[c][r] <= '0;
                end
            end
        end else if (wr_en_q) begin
            for (int c = 0; c < iopmp_pkg::NUM_CHAN; c++) begin
                if (wr_ofs_q == iopmp_pkg::OFS_CTRL + iopmp_pkg::WORD_BYTES * c) begin
                    ctrl_o[c] <= wr_ctrl;
                end
                for (int r = 0; r < iopmp_pkg::NUM_REGIONS; r++) begin
                    if (wr_ofs_q == region_ofs(c, r)) begin
                        region_o[c][r].base <= req_i.hwdata;
                    end
                    if (wr_ofs_q == region_ofs(c, r) + iopmp_pkg::WORD_BYTES) begin
                        region_o[c][r].mask <= req_i.hwdata;
                    end
                end
            end
        end
    end

    // Unmapped offsets fall through to 0.
    always_comb begin
        rd_data = '0;
        for (int c = 0; c < iopmp_pkg::NUM_CHAN; c++) begin
            if (ap_ofs == iopmp_pkg::OFS_CTRL + iopmp_pkg::WORD_BYTES * c) begin
                rd_data = ctrl_o[c];
            end
            if (ap_ofs == iopmp_pkg::OFS_STAT + iopmp_pkg::WORD_BYTES * c) begin
                rd_data = stat_i[c];
            end
            if (ap_ofs == iopmp_pkg::OFS_DUMP + iopmp_pkg::DUMP_BYTES * c) begin
                rd_data = dump_i[c].addr_w;
            end
            if (ap_ofs == iopmp_pkg::OFS_DUMP + iopmp_pkg::DUMP_BYTES * c
                          + iopmp_pkg::WORD_BYTES) begin
                rd_data = dump_i[c].addr_r;
            end
            for (int r = 0; r < iopmp_pkg::NUM_REGIONS; r++) begin
                if (ap_ofs == region_ofs(c, r)) begin
                    rd_data = region_o[c][r].base;
                end
                if (ap_ofs == region_ofs(c, r) + iopmp_pkg::WORD_BYTES) begin
                    rd_data = region_o[c][r].mask;
                end
            end
        end
    end

    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            hrdata_q <= '0;
        end else if (hsel_i && active && !req_i.hwrite) begin
            hrdata_q <= rd_data;  // Valid in the data phase.
        end
    end

    assign rsp_o = '{
        hresp:  iopmp_pkg::HRESP_OKAY,
        hready: 1'b1,
        hrdata: hrdata_q
    };

endmodule

/* hw/iopmp_channel.sv */
module iopmp_channel (
    input  logic                   hclk_i,
    input  logic                   hresetn_i,

    input  iopmp_pkg::pmp_ctrl_t   ctrl_i,
    input  iopmp_pkg::pmp_region_t region_i [iopmp_pkg::NUM_REGIONS],

    input  iopmp_pkg::ahb_req_t    slv_req_i,
    output iopmp_pkg::ahb_rsp_t    slv_rsp_o,

    output iopmp_pkg::ahb_req_t    mst_req_o,
    input  iopmp_pkg::ahb_rsp_t    mst_rsp_i,

    output iopmp_pkg::pmp_stat_t   stat_o,
    output iopmp_pkg::pmp_dump_t   dump_o
);

    logic [iopmp_pkg::NUM_REGIONS-1:0] addr_match;
    logic [iopmp_pkg::NUM_REGIONS-1:0] hit_w;
    logic [iopmp_pkg::NUM_REGIONS-1:0] hit_r;
    logic                              allow;
    logic                              active;
    logic                              accept;

    logic [iopmp_pkg::NUM_REGIONS-1:0] hit_w_q;
    logic [iopmp_pkg::NUM_REGIONS-1:0] hit_r_q;
    logic                              err_w_q;
    logic                              err_r_q;
    logic [iopmp_pkg::ADDR_W-1:0]      dump_w_q;
    logic [iopmp_pkg::ADDR_W-1:0]      dump_r_q;

    always_comb begin
        for (int i = 0; i < iopmp_pkg::NUM_REGIONS; i++) begin
            addr_match[i] = (slv_req_i.haddr & region_i[i].mask) == region_i[i].base;
        end
    end

    assign hit_w = addr_match & ctrl_i.en_w & {iopmp_pkg::NUM_REGIONS{slv_req_i.hwrite}};
    assign hit_r = addr_match & ctrl_i.en_r & {iopmp_pkg::NUM_REGIONS{!slv_req_i.hwrite}};
    assign allow = |{hit_w, hit_r};

    assign active = (slv_req_i.htrans == iopmp_pkg::HTRANS_NONSEQ) ||
                    (slv_req_i.htrans == iopmp_pkg::HTRANS_SEQ);
    assign accept = active && mst_rsp_i.hready;

    always_comb begin
        mst_req_o = slv_req_i;
        if (!allow) begin
            mst_req_o.htrans = iopmp_pkg::HTRANS_IDLE;  // Blocked.
        end
    end

    assign slv_rsp_o = mst_rsp_i;

    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            hit_w_q  <= '0;
            hit_r_q  <= '0;
            err_w_q  <= 1'b0;
            err_r_q  <= 1'b0;
            dump_w_q <= '0;
            dump_r_q <= '0;
        end else if (ctrl_i.rst) begin
            hit_w_q  <= '0;
            hit_r_q  <= '0;
            err_w_q  <= 1'b0;
            err_r_q  <= 1'b0;
            dump_w_q <= '0;
            dump_r_q <= '0;
        end else if (accept) begin
            if (slv_req_i.hwrite) begin
                if (|hit_w) begin
                    hit_w_q <= hit_w;
                end else begin
                    err_w_q  <= 1'b1;  // Sticky until rst.
                    dump_w_q <= slv_req_i.haddr;
                end
            end else begin
                if (|hit_r) begin
                    hit_r_q <= hit_r;
                end else begin
                    err_r_q  <= 1'b1;
                    dump_r_q <= slv_req_i.haddr;
                end
            end
        end
    end

    assign stat_o = '{
        hit_w: hit_w_q,
        hit_r: hit_r_q,
        rsvd:  '0,
        err_w: err_w_q,
        err_r: err_r_q
    };

    assign dump_o = '{
        addr_w: dump_w_q,
        addr_r: dump_r_q
    };

endmodule

/* hw/iopmp_top.sv */
module iopmp_top (
    input  logic                hclk_i,
    input  logic                hresetn_i,

    input  logic                cfg_hsel_i,
    input  iopmp_pkg::ahb_req_t cfg_req_i,
    output iopmp_pkg::ahb_rsp_t cfg_rsp_o,

    input  iopmp_pkg::ahb_req_t slv_req_i [iopmp_pkg::NUM_CHAN],
    output iopmp_pkg::ahb_rsp_t slv_rsp_o [iopmp_pkg::NUM_CHAN],

    output iopmp_pkg::ahb_req_t mst_req_o [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::ahb_rsp_t mst_rsp_i [iopmp_pkg::NUM_CHAN]
);

    iopmp_pkg::pmp_ctrl_t   ctrl   [iopmp_pkg::NUM_CHAN];
    iopmp_pkg::pmp_region_t region [iopmp_pkg::NUM_CHAN][iopmp_pkg::NUM_REGIONS];
    iopmp_pkg::pmp_stat_t   stat   [iopmp_pkg::NUM_CHAN];
    iopmp_pkg::pmp_dump_t   dump   [iopmp_pkg::NUM_CHAN];

    iopmp_cfg_regs u_cfg_regs (
        .hclk_i    (hclk_i),
        .hresetn_i (hresetn_i),
        .hsel_i    (cfg_hsel_i),
        .req_i     (cfg_req_i),
        .rsp_o     (cfg_rsp_o),
        .stat_i    (stat),
        .dump_i    (dump),
        .ctrl_o    (ctrl),
        .region_o  (region)
    );

    // Channels are peers on separate buses.
    for (genvar c = 0; c < iopmp_pkg::NUM_CHAN; c++) begin : g_chan
        iopmp_channel u_channel (
            .hclk_i    (hclk_i),
            .hresetn_i (hresetn_i),
            .ctrl_i    (ctrl[c]),
            .region_i  (region[c]),
            .slv_req_i (slv_req_i[c]),
            .slv_rsp_o (slv_rsp_o[c]),
            .mst_req_o (mst_req_o[c]),
            .mst_rsp_i (mst_rsp_i[c]),
            .stat_o    (stat[c]),
            .dump_o    (dump[c])
        );
    end

endmodule

/* tests/iopmp_asserts.sv */
module iopmp_asserts (
    input  logic                 hclk_i,
    input  logic                 hresetn_i,
    input  iopmp_pkg::ahb_rsp_t  cfg_rsp_i,
    input  iopmp_pkg::ahb_req_t  slv_req_i [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::ahb_rsp_t  slv_rsp_i [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::ahb_req_t  mst_req_i [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::ahb_rsp_t  mst_rsp_i [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::pmp_ctrl_t ctrl_i    [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::pmp_stat_t stat_i    [iopmp_pkg::NUM_CHAN],
    input  iopmp_pkg::pmp_dump_t dump_i    [iopmp_pkg::NUM_CHAN]
);

    int unsigned fail_cnt = 0;

    // Every request field except htrans.
    function automatic logic same_but_htrans(input iopmp_pkg::ahb_req_t a,
                                             input iopmp_pkg::ahb_req_t b);
        return a.haddr == b.haddr && a.hprot == b.hprot && a.hsize == b.hsize &&
               a.hburst == b.hburst && a.hwrite == b.hwrite && a.hwdata == b.hwdata;
    endfunction

    a_cfg_okay: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
        cfg_rsp_i.hresp == iopmp_pkg::HRESP_OKAY && cfg_rsp_i.hready)
    else begin
        $error("Configuration port gave an error or a wait state.");
        fail_cnt++;
    end

    for (genvar c = 0; c < iopmp_pkg::NUM_CHAN; c++) begin : g_chan
        logic active;
        logic accept;
        logic blocked;

        assign active  = slv_req_i[c].htrans[1];  // NONSEQ or SEQ.
        assign accept  = active && mst_rsp_i[c].hready && !ctrl_i[c].rst;
        assign blocked = mst_req_i[c].htrans == iopmp_pkg::HTRANS_IDLE;

        a_pass: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
            same_but_htrans(mst_req_i[c], slv_req_i[c]) && slv_rsp_i[c] == mst_rsp_i[c] &&
            (mst_req_i[c].htrans == slv_req_i[c].htrans || blocked))
        else begin
            $error("Channel %0d does not pass the transfer through unchanged.", c);
            fail_cnt++;
        end

        a_idle: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
            active && ctrl_i[c].en_w == '0 && ctrl_i[c].en_r == '0 |-> blocked)
        else begin
            $error("Channel %0d let a transfer through with all regions disabled.", c);
            fail_cnt++;
        end

        a_err_w: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
            accept && blocked && slv_req_i[c].hwrite |=>
            stat_i[c].err_w && dump_i[c].addr_w == $past(slv_req_i[c].haddr))
        else begin
            $error("Channel %0d did not record a blocked write.", c);
            fail_cnt++;
        end

        a_err_r: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
            accept && blocked && !slv_req_i[c].hwrite |=>
            stat_i[c].err_r && dump_i[c].addr_r == $past(slv_req_i[c].haddr))
        else begin
            $error("Channel %0d did not record a blocked read.", c);
            fail_cnt++;
        end

        a_stall: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
            !mst_rsp_i[c].hready && !ctrl_i[c].rst |=> $stable(stat_i[c]))
        else begin
            $error("Channel %0d status changed while the downstream stalled.", c);
            fail_cnt++;
        end
    end

endmodule

/* tests/tb_iopmp.sv */
module tb_iopmp;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;
    localparam int TIMEOUT    = NUM_TESTS * 200 * CLK_PERIOD;
    localparam int NC         = iopmp_pkg::NUM_CHAN;
    localparam int NR         = iopmp_pkg::NUM_REGIONS;

    logic                hclk;
    logic                hresetn;
    logic                cfg_hsel;
    iopmp_pkg::ahb_req_t cfg_req;
    iopmp_pkg::ahb_rsp_t cfg_rsp;
    iopmp_pkg::ahb_req_t slv_req [NC];
    iopmp_pkg::ahb_rsp_t slv_rsp [NC];
    iopmp_pkg::ahb_req_t mst_req [NC];
    iopmp_pkg::ahb_rsp_t mst_rsp [NC];

    logic [31:0] lfsr_state   = 32'd20;
    int          err_cnt      = 0;
    int          err_mark     = 0;
    int          failed_tests = 0;

    // Reference model of the register map.
    logic [7:0]  m_en_w   [NC];
    logic [7:0]  m_en_r   [NC];
    logic        m_rst    [NC];
    logic [31:0] m_base   [NC][NR];
    logic [31:0] m_mask   [NC][NR];
    logic [7:0]  m_hit_w  [NC];
    logic [7:0]  m_hit_r  [NC];
    logic        m_err_w  [NC];
    logic        m_err_r  [NC];
    logic [31:0] m_dump_w [NC];
    logic [31:0] m_dump_r [NC];

    iopmp_top u_iopmp_top (
        .hclk_i     (hclk),
        .hresetn_i  (hresetn),
        .cfg_hsel_i (cfg_hsel),
        .cfg_req_i  (cfg_req),
        .cfg_rsp_o  (cfg_rsp),
        .slv_req_i  (slv_req),
        .slv_rsp_o  (slv_rsp),
        .mst_req_o  (mst_req),
        .mst_rsp_i  (mst_rsp)
    );

    bind iopmp_top iopmp_asserts u_asserts (
        .hclk_i    (hclk_i),
        .hresetn_i (hresetn_i),
        .cfg_rsp_i (cfg_rsp_o),
        .slv_req_i (slv_req_i),
        .slv_rsp_i (slv_rsp_o),
        .mst_req_i (mst_req_o),
        .mst_rsp_i (mst_rsp_i),
        .ctrl_i    (ctrl),
        .stat_i    (stat),
        .dump_i    (dump)
    );

    initial hclk = 1'b0;
    always #(CLK_PERIOD / 2) hclk = ~hclk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return err_cnt + int'(u_iopmp_top.u_asserts.fail_cnt);
    endfunction

    // Regions of the access direction whose masked address equals the base.
    function automatic logic [7:0] expected_hits(input int c, input logic [31:0] addr,
                                                 input logic wr);
        logic [7:0] hits;
        hits = '0;
        for (int r = 0; r < NR; r++) begin
            hits[r] = (wr ? m_en_w[c][r] : m_en_r[c][r]) &&
                      ((addr & m_mask[c][r]) == m_base[c][r]);
        end
        return hits;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail at %0t: %s expected 0x%h, actual 0x%h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic cfg_write(input logic [7:0] ofs, input logic [31:0] data);
        @(negedge hclk);
        cfg_hsel       = 1'b1;
        cfg_req.haddr  = 32'(ofs);
        cfg_req.hwrite = 1'b1;
        cfg_req.htrans = iopmp_pkg::HTRANS_NONSEQ;
        @(negedge hclk);
        cfg_hsel       = 1'b0;
        cfg_req.htrans = iopmp_pkg::HTRANS_IDLE;
        cfg_req.hwdata = data;  // Data phase.
    endtask

    task automatic check_reg(input logic [7:0] ofs, input logic [31:0] exp);
        @(negedge hclk);
        cfg_hsel       = 1'b1;
        cfg_req.haddr  = 32'(ofs);
        cfg_req.hwrite = 1'b0;
        cfg_req.htrans = iopmp_pkg::HTRANS_NONSEQ;
        @(negedge hclk);
        cfg_hsel       = 1'b0;
        cfg_req.htrans = iopmp_pkg::HTRANS_IDLE;
        check($sformatf("cfg_rsp_o.hrdata[0x%h]", ofs), exp, cfg_rsp.hrdata);
    endtask

    task automatic write_ctrl(input int c, input logic [31:0] w);
        cfg_write(8'(iopmp_pkg::OFS_CTRL + 4 * c), w);
        m_en_w[c] = w[31:24];
        m_en_r[c] = w[23:16];
        m_rst[c]  = w[0];
        if (w[0]) begin
            m_hit_w[c]  = '0;
            m_hit_r[c]  = '0;
            m_err_w[c]  = 1'b0;
            m_err_r[c]  = 1'b0;
            m_dump_w[c] = '0;
            m_dump_r[c] = '0;
        end
    endtask

    task automatic write_region(input int c, input int r, input logic [31:0] base,
                                input logic [31:0] mask);
        cfg_write(8'(iopmp_pkg::OFS_REGION + 8 * (c * NR + r)), base);
        cfg_write(8'(iopmp_pkg::OFS_REGION + 8 * (c * NR + r) + 4), mask);
        m_base[c][r] = base;
        m_mask[c][r] = mask;
    endtask

    task automatic check_status(input int c);
        check_reg(8'(iopmp_pkg::OFS_STAT + 4 * c),
                  {m_hit_w[c], m_hit_r[c], 14'b0, m_err_w[c], m_err_r[c]});
        check_reg(8'(iopmp_pkg::OFS_DUMP + 8 * c), m_dump_w[c]);
        check_reg(8'(iopmp_pkg::OFS_DUMP + 8 * c + 4), m_dump_r[c]);
    endtask

    // One transfer, held under stall cycles of low hready before it is accepted.
    task automatic chan_xfer(input int c, input logic [31:0] addr, input logic wr,
                             input int stall);
        logic [7:0] hits;
        hits = expected_hits(c, addr, wr);
        @(negedge hclk);
        slv_req[c].haddr  = addr;
        slv_req[c].hwrite = wr;
        slv_req[c].hsize  = 3'b010;
        slv_req[c].hprot  = 4'(rand_bits(4));
        slv_req[c].htrans = iopmp_pkg::HTRANS_NONSEQ;
        mst_rsp[c].hready = (stall == 0);
        #(CLK_PERIOD / 4);
        check($sformatf("mst_req_o[%0d].htrans", c),
              hits != 0 ? iopmp_pkg::HTRANS_NONSEQ : iopmp_pkg::HTRANS_IDLE,
              32'(mst_req[c].htrans));
        for (int i = 0; i < stall; i++) begin
            @(negedge hclk);
            mst_rsp[c].hready = (i == stall - 1);
        end
        @(negedge hclk);
        slv_req[c].htrans = iopmp_pkg::HTRANS_IDLE;
        slv_req[c].hwdata = rand_bits(32);  // Data phase.
        mst_rsp[c].hrdata = rand_bits(32);
        mst_rsp[c].hready = 1'b1;
        if (!m_rst[c] && wr) begin
            if (hits != 0) begin
                m_hit_w[c] = hits;
            end else begin
                m_err_w[c]  = 1'b1;
                m_dump_w[c] = addr;
            end
        end else if (!m_rst[c]) begin
            if (hits != 0) begin
                m_hit_r[c] = hits;
            end else begin
                m_err_r[c]  = 1'b1;
                m_dump_r[c] = addr;
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        repeat (2) @(negedge hclk);  // Let late assertions fire.
        errs     = total_errors() - err_mark;
        err_mark = total_errors();
        if (errs != 0) begin
            failed_tests++;
        end
        $display("Test %0d %s: %s, %0d error(s)", num, name, errs == 0 ? "ok" : "failed", errs);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [31:0] base;
        logic [31:0] addr;
        int          k;
        hresetn  = 1'b0;
        cfg_hsel = 1'b0;
        cfg_req  = '0;
        for (int c = 0; c < NC; c++) begin
            slv_req[c]  = '0;
            mst_rsp[c]  = '{hresp: iopmp_pkg::HRESP_OKAY, hready: 1'b1, hrdata: '0};
            m_en_w[c]   = '0;
            m_en_r[c]   = '0;
            m_rst[c]    = 1'b0;
            m_hit_w[c]  = '0;
            m_hit_r[c]  = '0;
            m_err_w[c]  = 1'b0;
            m_err_r[c]  = 1'b0;
            m_dump_w[c] = '0;
            m_dump_r[c] = '0;
            for (int r = 0; r < NR; r++) begin
                m_base[c][r] = '0;
                m_mask[c][r] = '0;
            end
        end
        repeat (3) @(posedge hclk);
        @(negedge hclk);
        hresetn = 1'b1;

        check("cfg_rsp_o.hrdata", '0, cfg_rsp.hrdata);
        for (int c = 0; c < NC; c++) begin
            chan_xfer(c, rand_bits(32), 1'b1, 0);
            chan_xfer(c, rand_bits(32), 1'b0, 0);
            check_status(c);
        end
        end_test(1, "reset_blocks_all");

        for (int c = 0; c < NC; c++) begin
            w = rand_bits(32);
            write_ctrl(c, w);
            check_reg(8'(iopmp_pkg::OFS_CTRL + 4 * c), {w[31:16], 15'b0, w[0]});
            for (int r = 0; r < NR; r++) begin
                write_region(c, r, rand_bits(32), rand_bits(32));
                check_reg(8'(iopmp_pkg::OFS_REGION + 8 * (c * NR + r)), m_base[c][r]);
                check_reg(8'(iopmp_pkg::OFS_REGION + 8 * (c * NR + r) + 4), m_mask[c][r]);
            end
        end
        check_reg(8'hA0, '0);
        check_reg(8'hC0 + 8'(rand_bits(4) << 2), '0);  // Somewhere in 0xC0 to 0xFC.
        for (int c = 0; c < NC; c++) begin
            write_ctrl(c, '0);
        end
        end_test(2, "register_readback");

        // Channel 0 enables writes only, channel 1 reads only.
        for (int c = 0; c < NC; c++) begin
            k    = int'(rand_bits(3));
            base = rand_bits(32) & 32'hFFFF_F000;
            write_region(c, k, base, 32'hFFFF_F000);
            if (c == 0) begin
                write_ctrl(c, {8'(1 << k), 8'h00, 16'h0000});
            end else begin
                write_ctrl(c, {8'h00, 8'(1 << k), 16'h0000});
            end
            addr = base | rand_bits(12);
            chan_xfer(c, addr, 1'b1, 0);
            chan_xfer(c, addr, 1'b0, 0);
            check_status(c);
        end
        end_test(3, "region_hit");

        for (int c = 0; c < NC; c++) begin
            chan_xfer(c, rand_bits(32), 1'b1, 0);
            chan_xfer(c, rand_bits(32), 1'b0, 0);
            check_status(c);
        end
        end_test(4, "blocked_capture");

        for (int c = 0; c < NC; c++) begin
            chan_xfer(c, rand_bits(32), 1'b1, 3);
            chan_xfer(c, rand_bits(32), 1'b0, 2);
            check_status(c);
        end
        end_test(5, "stall_capture");

        for (int c = 0; c < NC; c++) begin
            write_ctrl(c, {m_en_w[c], m_en_r[c], 16'h0001});
            @(negedge hclk);  // Status clears at the edge after rst lands.
            check_status(c);
            write_ctrl(c, {m_en_w[c], m_en_r[c], 16'h0000});
            chan_xfer(c, rand_bits(32), 1'b0, 0);
            check_status(c);
        end
        end_test(6, "status_clear");

        $display("Summary: %0d of %0d tests passed, %0d error(s)",
                 NUM_TESTS - failed_tests, NUM_TESTS, total_errors());
        if (failed_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/iopmp_pkg.sv
hw/iopmp_cfg_regs.sv
hw/iopmp_channel.sv
hw/iopmp_top.sv
tests/iopmp_asserts.sv
tests/tb_iopmp.sv

/* Bender.yml */
package:
  name: iopmp

sources:
  - files:
      - hw/iopmp_pkg.sv
      - hw/iopmp_cfg_regs.sv
      - hw/iopmp_channel.sv
      - hw/iopmp_top.sv
  - target: test
    files:
      - tests/iopmp_asserts.sv
      - tests/tb_iopmp.sv
